// File: Makefile
# Verilator flow for the SCSI DMA controller

VERILATOR ?= verilator
TOP       ?= scsiDmacTb
RTL_TOP   ?= scsiDmac
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
src/dmacRegPkg.sv
src/dmacBusPkg.sv
src/dmacRegs.sv
src/dmaFifo.sv
src/scsiPortSm.sv
src/busMasterSm.sv
src/scsiDmac.sv
verif/scsiChipModel.sv
verif/scsiDmacTb.sv

// File: src/busMasterSm.sv
////////////////////////////////////////////////////////////////////////////
// Memory bus master moving one longword per bus tenure
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module busMasterSm
    import dmacRegPkg::*, dmacBusPkg::*;
(
    input  wire           nSCLK,
    input  wire           nAS_,
    input  wire dmaCtrl_t ctrl_i,
    input  wire           wordsLeft_i,
    input  wire           fifoEmpty_i,
    input  wire           fifoFull_i,
    input  wire  [29:0]   maddr_i,
    input  wire  [31:0]   fifoWord_i,
    input  wire  [31:0]   memRdata_i,
    input  wire           memAck_i,
    input  wire           busGrant_i,
    output logic          busReq_o,
    output logic          own_o,
    output memReq_t       mem_o,
    output logic [31:0]   rdWord_o,
    output logic          wordPush_o,
    output logic          wordPop_o,
    output logic          wordDone_o
);

    masterState_t state;
    logic         wantBus;

    // dmaDir set means memory feeds the FIFO
    assign wantBus = ctrl_i.dmaEna && wordsLeft_i &&
                     (ctrl_i.dmaDir ? !fifoFull_i : !fifoEmpty_i);

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            state <= BM_IDLE;
        end else begin
            case (state)
                BM_IDLE: if (wantBus) state <= BM_REQ;
                BM_REQ:  if (busGrant_i) state <= BM_XFER;
                BM_XFER: if (memAck_i) state <= BM_NEXT;
                default: state <= BM_IDLE;    // Counters settle in BM_NEXT
            endcase
        end
    end

    always_ff @(posedge nSCLK) begin
        if (state == BM_XFER && memAck_i)
            rdWord_o <= memRdata_i;    // Pushed on the following cycle
    end

    assign busReq_o = (state == BM_REQ);
    assign own_o    = (state == BM_XFER);

    always_comb begin
        mem_o.strobe = own_o;
        mem_o.write  = own_o && !ctrl_i.dmaDir;
        mem_o.addr   = maddr_i;
        mem_o.wdata  = fifoWord_i;
    end

    assign wordPush_o = (state == BM_NEXT) && ctrl_i.dmaDir;
    assign wordPop_o  = (state == BM_NEXT) && !ctrl_i.dmaDir;
    assign wordDone_o = (state == BM_NEXT);

endmodule

`default_nettype wire

// File: src/dmaFifo.sv
////////////////////////////////////////////////////////////////////////////
// Longword FIFO that packs and unpacks bytes on the peripheral side
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module dmaFifo
    import dmacRegPkg::*;
(
    input  wire         nSCLK,
    input  wire         nAS_,
    input  wire         flush_i,
    input  wire  [7:0]  byteIn_i,
    input  wire         bytePush_i,
    input  wire         bytePop_i,
    output logic [7:0]  byteOut_o,
    input  wire  [31:0] wordIn_i,
    input  wire         wordPush_i,
    input  wire         wordPop_i,
    output logic [31:0] wordOut_o,
    output logic        empty_o,
    output logic        full_o
);

    logic [31:0]        mem [FIFO_DEPTH];
    logic [FIFO_AW:0]   wrPtr;    // Top bit tells full from empty
    logic [FIFO_AW:0]   rdPtr;
    logic [FIFO_AW-1:0] wrIdx;
    logic [FIFO_AW-1:0] rdIdx;
    logic [1:0]         byteOff;    // Byte 0 sits in bits 7:0

    assign wrIdx = wrPtr[FIFO_AW-1:0];
    assign rdIdx = rdPtr[FIFO_AW-1:0];

    assign empty_o = (wrPtr == rdPtr);
    assign full_o  = (wrIdx == rdIdx) && (wrPtr[FIFO_AW] != rdPtr[FIFO_AW]);

    assign wordOut_o = mem[rdIdx];
    assign byteOut_o = wordOut_o[{byteOff, 3'b000} +: 8];

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            byteOff <= '0;
        end else if (flush_i) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            byteOff <= '0;
        end else begin
            // Fourth byte completes the word
            if (wordPush_i || (bytePush_i && byteOff == 2'd3))
                wrPtr <= wrPtr + 1'b1;
            if (wordPop_i || (bytePop_i && byteOff == 2'd3))
                rdPtr <= rdPtr + 1'b1;
            if (bytePush_i || bytePop_i)
                byteOff <= byteOff + 2'd1;
        end
    end

    // Bytes fill the open word one lane at a time
    always_ff @(posedge nSCLK) begin
        if (wordPush_i)
            mem[wrIdx] <= wordIn_i;
        else if (bytePush_i)
            mem[wrIdx][{byteOff, 3'b000} +: 8] <= byteIn_i;
    end

endmodule

`default_nettype wire

// File: src/dmacBusPkg.sv
////////////////////////////////////////////////////////////////////////////
// Bus request structs and FSM state encodings for the SCSI DMA controller
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package dmacBusPkg;

    // CPU register access request
    typedef struct packed {
        logic        sel;      // Single-cycle strobe
        logic        write;
        logic [4:0]  addr;
        logic [31:0] wdata;
    } cpuReq_t;

    // Memory bus cycle driven while bus master
    typedef struct packed {
        logic        strobe;
        logic        write;
        logic [29:0] addr;     // Longword address
        logic [31:0] wdata;
    } memReq_t;

    // Active high peripheral port strobes
    typedef struct packed {
        logic cs;
        logic ior;
        logic iow;
        logic dack;
    } pdCtrl_t;

    typedef enum logic [1:0] {
        SC_IDLE,
        SC_REGCYC,
        SC_DMACYC,
        SC_DONE
    } scsiState_t;

    typedef enum logic [1:0] {
        BM_IDLE,
        BM_REQ,
        BM_XFER,
        BM_NEXT
    } masterState_t;

endpackage

`default_nettype wire

// File: src/dmacRegPkg.sv
////////////////////////////////////////////////////////////////////////////
// SCSI DMA controller register map, control bits and FIFO sizing
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package dmacRegPkg;

    // Longword register addresses
    localparam logic [4:0] ADDR_CTRL   = 5'd0;
    localparam logic [4:0] ADDR_STATUS = 5'd1;
    localparam logic [4:0] ADDR_MADDR  = 5'd2;
    localparam logic [4:0] ADDR_COUNT  = 5'd3;
    localparam logic [4:0] ADDR_SCSI   = 5'd4;    // Byte window onto the SCSI chip

    // Control register with dmaEna in bit 0
    typedef struct packed {
        logic intEna;
        logic dmaDir;    // 1 for memory to peripheral
        logic dmaEna;
    } dmaCtrl_t;

    // Status word bit positions
    localparam int STAT_EMPTY   = 0;
    localparam int STAT_FULL    = 1;
    localparam int STAT_DONE    = 2;    // Write 1 to clear
    localparam int STAT_SCSIINT = 3;

    localparam int FIFO_DEPTH = 4;    // Longwords
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

endpackage

`default_nettype wire

// File: src/dmacRegs.sv
////////////////////////////////////////////////////////////////////////////
// CPU register file with address and count counters and interrupt logic
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module dmacRegs
    import dmacRegPkg::*, dmacBusPkg::*;
(
    input  wire cpuReq_t cpu_i,
    input  wire          nSCLK,
    input  wire          nAS_,
    output logic         regAck_o,
    output logic [31:0]  rdata_o,
    output dmaCtrl_t     ctrl_o,
    output logic [29:0]  maddr_o,
    output logic         wordsLeft_o,
    input  wire          wordDone_i,
    input  wire          fifoEmpty_i,
    input  wire          fifoFull_i,
    input  wire          scsiInt_i,
    input  wire  [7:0]   scsiRdByte_i,
    input  wire          scsiCycDone_i,
    output logic         int_o
);

    logic [31:0] count;
    logic [31:0] statusWord;
    logic        done;
    logic        lastWord;    // Final word went through last cycle
    logic        regHit;
    logic        regWr;

    // Window accesses are acked later, when the port cycle ends
    assign regHit = cpu_i.sel && (cpu_i.addr != ADDR_SCSI);
    assign regWr  = regHit && cpu_i.write;

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            ctrl_o   <= '0;
            maddr_o  <= '0;
            count    <= '0;
            done     <= 1'b0;
            lastWord <= 1'b0;
            regAck_o <= 1'b0;
        end else begin
            regAck_o <= regHit || scsiCycDone_i;
            lastWord <= wordDone_i && (count == 32'd1);
            if (regWr && cpu_i.addr == ADDR_CTRL)
                ctrl_o <= cpu_i.wdata[$bits(dmaCtrl_t)-1:0];
            if (regWr && cpu_i.addr == ADDR_MADDR)
                maddr_o <= cpu_i.wdata[31:2];
            else if (wordDone_i)
                maddr_o <= maddr_o + 30'd1;    // Next longword
            if (regWr && cpu_i.addr == ADDR_COUNT)
                count <= cpu_i.wdata;
            else if (wordDone_i && wordsLeft_o)
                count <= count - 32'd1;
            if (lastWord)
                done <= 1'b1;
            else if (regWr && cpu_i.addr == ADDR_STATUS && cpu_i.wdata[STAT_DONE])
                done <= 1'b0;
        end
    end

    always_comb begin
        statusWord               = '0;
        statusWord[STAT_EMPTY]   = fifoEmpty_i;
        statusWord[STAT_FULL]    = fifoFull_i;
        statusWord[STAT_DONE]    = done;
        statusWord[STAT_SCSIINT] = scsiInt_i;
    end

    // Read data lines up with the ack pulse
    always_ff @(posedge nSCLK) begin
        if (scsiCycDone_i) begin
            rdata_o <= {24'd0, scsiRdByte_i};    // Byte from the SCSI chip
        end else if (regHit) begin
            case (cpu_i.addr)
                ADDR_CTRL:   rdata_o <= 32'(ctrl_o);
                ADDR_STATUS: rdata_o <= statusWord;
                ADDR_MADDR:  rdata_o <= {maddr_o, 2'b00};
                ADDR_COUNT:  rdata_o <= count;
                default:     rdata_o <= '0;
            endcase
        end
    end

    assign wordsLeft_o = (count != '0);
    assign int_o       = ctrl_o.intEna && (done || scsiInt_i);

endmodule

`default_nettype wire

// File: src/scsiDmac.sv
////////////////////////////////////////////////////////////////////////////
// SCSI DMA controller top joining registers, FIFO and both FSMs
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module scsiDmac
    import dmacRegPkg::*, dmacBusPkg::*;
(
    input  wire          nSCLK,
    input  wire          nAS_,
    // CPU register port
    input  wire cpuReq_t cpu_i,
    output logic [31:0]  cpuRdata_o,
    output logic         cpuAck_o,
    // Memory side
    output memReq_t      mem_o,
    input  wire  [31:0]  memRdata_i,
    input  wire          memAck_i,
    output logic         busReq_o,
    input  wire          busGrant_i,
    output logic         own_o,
    // Peripheral port
    output pdCtrl_t      pd_o,
    output logic [7:0]   pdWdata_o,
    input  wire  [7:0]   pdRdata_i,
    input  wire          dreq_i,
    input  wire          scsiInt_i,
    output logic         int_o
);

    dmaCtrl_t    dmaCtrl;
    dmaCtrl_t    newCtrl;
    logic [29:0] maddr;
    logic        wordsLeft;
    logic        wordDone;
    logic        fifoEmpty;
    logic        fifoFull;
    logic        fifoFlush;
    logic        bytePush;
    logic        bytePop;
    logic        wordPush;
    logic        wordPop;
    logic        cycDone;
    logic [7:0]  fifoByte;
    logic [7:0]  rdByte;
    logic [31:0] fifoWord;
    logic [31:0] rdWord;

    // Starting a new DMA empties the FIFO
    assign newCtrl   = cpu_i.wdata[$bits(dmaCtrl_t)-1:0];
    assign fifoFlush = cpu_i.sel && cpu_i.write && (cpu_i.addr == ADDR_CTRL) &&
                       newCtrl.dmaEna && !dmaCtrl.dmaEna;

    dmacRegs uRegs (
        .nSCLK         (nSCLK),
        .nAS_          (nAS_),
        .cpu_i         (cpu_i),
        .regAck_o      (cpuAck_o),
        .rdata_o       (cpuRdata_o),
        .ctrl_o        (dmaCtrl),
        .maddr_o       (maddr),
        .wordsLeft_o   (wordsLeft),
        .wordDone_i    (wordDone),
        .fifoEmpty_i   (fifoEmpty),
        .fifoFull_i    (fifoFull),
        .scsiInt_i     (scsiInt_i),
        .scsiRdByte_i  (rdByte),
        .scsiCycDone_i (cycDone),
        .int_o         (int_o)
    );

    dmaFifo uFifo (
        .nSCLK      (nSCLK),
        .nAS_       (nAS_),
        .flush_i    (fifoFlush),
        .byteIn_i   (rdByte),
        .bytePush_i (bytePush),
        .bytePop_i  (bytePop),
        .byteOut_o  (fifoByte),
        .wordIn_i   (rdWord),
        .wordPush_i (wordPush),
        .wordPop_i  (wordPop),
        .wordOut_o  (fifoWord),
        .empty_o    (fifoEmpty),
        .full_o     (fifoFull)
    );

    scsiPortSm uScsiSm (
        .nSCLK       (nSCLK),
        .nAS_        (nAS_),
        .cpu_i       (cpu_i),
        .ctrl_i      (dmaCtrl),
        .dreq_i      (dreq_i),
        .fifoEmpty_i (fifoEmpty),
        .fifoFull_i  (fifoFull),
        .fifoByte_i  (fifoByte),
        .pdRdata_i   (pdRdata_i),
        .pd_o        (pd_o),
        .pdWdata_o   (pdWdata_o),
        .bytePush_o  (bytePush),
        .bytePop_o   (bytePop),
        .rdByte_o    (rdByte),
        .cycDone_o   (cycDone)
    );

    busMasterSm uBusSm (
        .nSCLK       (nSCLK),
        .nAS_        (nAS_),
        .ctrl_i      (dmaCtrl),
        .wordsLeft_i (wordsLeft),
        .fifoEmpty_i (fifoEmpty),
        .fifoFull_i  (fifoFull),
        .maddr_i     (maddr),
        .fifoWord_i  (fifoWord),
        .memRdata_i  (memRdata_i),
        .memAck_i    (memAck_i),
        .busGrant_i  (busGrant_i),
        .busReq_o    (busReq_o),
        .own_o       (own_o),
        .mem_o       (mem_o),
        .rdWord_o    (rdWord),
        .wordPush_o  (wordPush),
        .wordPop_o   (wordPop),
        .wordDone_o  (wordDone)
    );

endmodule

`default_nettype wire

// File: src/scsiPortSm.sv
////////////////////////////////////////////////////////////////////////////
// Peripheral port FSM for register window cycles and DMA byte cycles
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module scsiPortSm
    import dmacRegPkg::*, dmacBusPkg::*;
(
    input  wire           nSCLK,
    input  wire           nAS_,
    input  wire cpuReq_t  cpu_i,
    input  wire dmaCtrl_t ctrl_i,
    input  wire           dreq_i,
    input  wire           fifoEmpty_i,
    input  wire           fifoFull_i,
    input  wire  [7:0]    fifoByte_i,
    input  wire  [7:0]    pdRdata_i,
    output pdCtrl_t       pd_o,
    output logic [7:0]    pdWdata_o,
    output logic          bytePush_o,
    output logic          bytePop_o,
    output logic [7:0]    rdByte_o,
    output logic          cycDone_o
);

    scsiState_t state;
    logic [1:0] strobeCnt;
    logic       lastStrobe;
    logic       strobeOn;
    logic       isReg;       // Current cycle is a window access
    logic       isWrite;
    logic       winHit;
    logic       winPend;     // Window access waiting for the port
    logic       winWrite;
    logic [7:0] winData;
    logic       dmaGo;

    assign winHit     = cpu_i.sel && (cpu_i.addr == ADDR_SCSI);
    assign lastStrobe = (strobeCnt == 2'd2);

    // No writes from an empty FIFO, no reads into a full one
    assign dmaGo = ctrl_i.dmaEna && dreq_i &&
                   (ctrl_i.dmaDir ? !fifoEmpty_i : !fifoFull_i);

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_)
            winPend <= 1'b0;
        else if (winHit)
            winPend <= 1'b1;
        else if (state == SC_IDLE)
            winPend <= 1'b0;    // Taken up by the idle state
    end

    always_ff @(posedge nSCLK) begin
        if (winHit) begin
            winWrite <= cpu_i.write;
            winData  <= cpu_i.wdata[7:0];
        end
    end

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            state     <= SC_IDLE;
            strobeCnt <= '0;
            isReg     <= 1'b0;
            isWrite   <= 1'b0;
        end else begin
            case (state)
                SC_IDLE: begin
                    strobeCnt <= '0;
                    if (winPend) begin    // Window wins over DMA
                        state   <= SC_REGCYC;
                        isReg   <= 1'b1;
                        isWrite <= winWrite;
                    end else if (dmaGo) begin
                        state   <= SC_DMACYC;
                        isReg   <= 1'b0;
                        isWrite <= ctrl_i.dmaDir;
                    end
                end
                SC_REGCYC, SC_DMACYC: begin
                    strobeCnt <= strobeCnt + 2'd1;
                    if (lastStrobe)
                        state <= SC_DONE;
                end
                default: state <= SC_IDLE;
            endcase
        end
    end

    // Write byte held for the whole strobe, read byte taken on its last cycle
    always_ff @(posedge nSCLK) begin
        if (state == SC_IDLE)
            pdWdata_o <= winPend ? winData : fifoByte_i;
        if ((state == SC_REGCYC || state == SC_DMACYC) && lastStrobe)
            rdByte_o <= pdRdata_i;
    end

    // Window cycles keep the strobe through the done state
    assign strobeOn = (state == SC_REGCYC) || (state == SC_DMACYC) ||
                      (state == SC_DONE && isReg);

    always_comb begin
        pd_o.cs   = strobeOn && isReg;
        pd_o.dack = strobeOn && !isReg;
        pd_o.ior  = strobeOn && !isWrite;
        pd_o.iow  = strobeOn && isWrite;
    end

    assign bytePush_o = (state == SC_DONE) && !isReg && !isWrite;
    assign bytePop_o  = (state == SC_DONE) && !isReg && isWrite;
    assign cycDone_o  = (state == SC_DONE) && isReg;

endmodule

`default_nettype wire

// File: verif/scsiChipModel.sv
////////////////////////////////////////////////////////////////////////////
// Behavioral SCSI chip with a register byte, DREQ byte source and sink
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module scsiChipModel
    import dmacBusPkg::*;
(
    input  wire          nSCLK,
    input  wire          nAS_,
    input  wire pdCtrl_t pd_i,
    input  wire  [7:0]   wdata_i,
    output logic [7:0]   rdata_o,
    input  wire          dreqEna_i,
    input  wire          clear_i,      // Restart source and log
    input  wire  [7:0]   limit_i,      // Bytes to move per transfer
    output logic         dreq_o,
    output logic [7:0]   logCount_o
);

    logic [7:0] srcBytes [64];    // Filled by the testbench
    logic [7:0] logBytes [64];
    logic [7:0] idx;
    logic [7:0] regByte;
    logic       prevDack;
    logic       prevCs;
    logic       prevIow;

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            idx        <= '0;
            logCount_o <= '0;
            regByte    <= 8'h3C;
            prevDack   <= 1'b0;
            prevCs     <= 1'b0;
            prevIow    <= 1'b0;
        end else if (clear_i) begin
            idx        <= '0;
            logCount_o <= '0;
        end else begin
            prevDack <= pd_i.dack;
            prevCs   <= pd_i.cs;
            prevIow  <= pd_i.iow;
            // Byte cycle ends when dack drops
            if (prevDack && !pd_i.dack) begin
                if (prevIow) begin
                    logBytes[logCount_o[5:0]] <= wdata_i;
                    logCount_o <= logCount_o + 8'd1;
                end else begin
                    idx <= idx + 8'd1;
                end
            end
            if (prevCs && !pd_i.cs && prevIow)
                regByte <= wdata_i;    // Register write lands at end of cs
        end
    end

    assign rdata_o = pd_i.cs ? regByte : srcBytes[idx[5:0]];
    assign dreq_o  = dreqEna_i && ((idx + logCount_o) < limit_i);

endmodule

`default_nettype wire

// File: verif/scsiDmacTb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the SCSI DMA controller with memory and chip models
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module scsiDmacTb
    import dmacRegPkg::*, dmacBusPkg::*;
;

    localparam int NWORDS      = 4;
    localparam int TOTAL_BYTES = 2 * NWORDS * 4;
    localparam int WDOG_CYCLES = TOTAL_BYTES * 40 + 2000;

    logic        nSCLK;
    logic        nAS_;
    cpuReq_t     cpu;
    logic [31:0] cpuRdata;
    logic        cpuAck;
    memReq_t     mem;
    logic [31:0] memRdata;
    logic        memAck;
    logic        busReq;
    logic        busGrant;
    logic        own;
    pdCtrl_t     pd;
    logic [7:0]  pdWdata;
    logic [7:0]  pdRdata;
    logic        dreq;
    logic        scsiInt;
    logic        intOut;
    logic        dreqEna;
    logic        chipClear;
    logic [7:0]  logCount;
    logic [7:0]  winExp;
    logic        intEnaSh;    // Testbench copy of intEna
    logic [31:0] memArr [256];
    int          errCount;
    int          protoCount;

    scsiDmac dut (
        .nSCLK(nSCLK), .nAS_(nAS_), .cpu_i(cpu), .cpuRdata_o(cpuRdata),
        .cpuAck_o(cpuAck), .mem_o(mem), .memRdata_i(memRdata), .memAck_i(memAck),
        .busReq_o(busReq), .busGrant_i(busGrant), .own_o(own), .pd_o(pd),
        .pdWdata_o(pdWdata), .pdRdata_i(pdRdata), .dreq_i(dreq),
        .scsiInt_i(scsiInt), .int_o(intOut)
    );

    scsiChipModel chip (
        .nSCLK(nSCLK), .nAS_(nAS_), .pd_i(pd), .wdata_i(pdWdata), .rdata_o(pdRdata),
        .dreqEna_i(dreqEna), .clear_i(chipClear), .limit_i(8'(NWORDS * 4)),
        .dreq_o(dreq), .logCount_o(logCount)
    );

    initial begin
        nSCLK = 1'b0;
        forever #50 nSCLK = ~nSCLK;
    end

    // Bus protocol and interrupt gating
    assert property (@(posedge nSCLK) disable iff (!nAS_) mem.strobe |-> own)
        else begin protoCount++; $display("error at %0t: strobe while not owner", $time); end
    assert property (@(posedge nSCLK) disable iff (!nAS_) $rose(own) |-> $past(busGrant))
        else begin protoCount++; $display("error at %0t: own without grant", $time); end
    assert property (@(posedge nSCLK) disable iff (!nAS_) $fell(busReq) |-> $past(busGrant))
        else begin protoCount++; $display("error at %0t: busReq dropped early", $time); end
    assert property (@(posedge nSCLK) disable iff (!nAS_) !intEnaSh |-> !intOut)
        else begin protoCount++; $display("error at %0t: int_o while disabled", $time); end
    assert property (@(posedge nSCLK) disable iff (!nAS_) (pd.cs && pd.iow) |-> pdWdata == winExp)
        else begin errCount++; $display("error at %0t: window write byte wrong", $time); end

    // Grant arrives after a random wait
    always begin
        @(negedge nSCLK);
        if (busReq) begin
            repeat ($urandom_range(0, 3)) @(negedge nSCLK);
            busGrant = 1'b1;
            @(negedge nSCLK);
            busGrant = 1'b0;
        end
    end

    // Memory acks 1 to 4 cycles into the strobe
    always begin
        @(negedge nSCLK);
        if (mem.strobe) begin
            repeat ($urandom_range(0, 3)) @(negedge nSCLK);
            memAck   = 1'b1;
            memRdata = memArr[mem.addr[7:0]];
            if (mem.write)
                memArr[mem.addr[7:0]] = mem.wdata;
            @(negedge nSCLK);
            memAck = 1'b0;
        end
    end

    initial begin
        #(WDOG_CYCLES * 100);
        $display("Watchdog timeout, the DMA transfers did not complete");
        $display("Simulation failed");
        $finish;
    end

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        assert (got == exp)
            else begin
                errCount++;
                $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
            end
    endtask

    task automatic cpuAccess(input logic wr, input logic [4:0] a, input logic [31:0] d,
                             output logic [31:0] rd);
        int n;
        n = 0;
        @(negedge nSCLK);
        cpu.sel   = 1'b1;
        cpu.write = wr;
        cpu.addr  = a;
        cpu.wdata = d;
        @(negedge nSCLK);
        cpu.sel = 1'b0;
        while (!cpuAck && n < 20) begin
            @(negedge nSCLK);
            n++;
        end
        if (!cpuAck) begin
            protoCount++;
            $display("CPU access at %0t got no acknowledge", $time);
        end
        rd = cpuRdata;
    endtask

    task automatic regWrite(input logic [4:0] a, input logic [31:0] d);
        logic [31:0] dummy;
        cpuAccess(1'b1, a, d, dummy);
    endtask

    task automatic setCtrl(input dmaCtrl_t c);
        if (c.intEna)
            intEnaSh = 1'b1;
        regWrite(ADDR_CTRL, 32'(c));
        intEnaSh = c.intEna;    // Clears only after the write lands
    endtask

    task automatic waitDone();
        logic [31:0] st;
        st = '0;
        while (!st[STAT_DONE])
            cpuAccess(1'b0, ADDR_STATUS, '0, st);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] exp;
        logic [31:0] srcWords [NWORDS];    // Words the read DMA must deliver
        void'($urandom(67932));
        nAS_ = 1'b0;
        cpu = '0;
        memRdata = '0;
        memAck = 1'b0;
        busGrant = 1'b0;
        scsiInt = 1'b0;
        dreqEna = 1'b0;
        chipClear = 1'b0;
        winExp = 8'hA5;
        intEnaSh = 1'b0;
        errCount = 0;
        protoCount = 0;
        for (int i = 0; i < 256; i++)
            memArr[i] = {i[7:0] ^ 8'h5A, ~i[7:0], i[7:0], 8'hC3 ^ i[7:0]};
        for (int i = 0; i < 64; i++)
            chip.srcBytes[i] = 8'($urandom);
        repeat (4) @(negedge nSCLK);
        nAS_ = 1'b1;

        // Reset values and register readback
        checkValue({cpuAck, busReq, own, mem.strobe, pd, intOut}, '0, "outputs after reset");
        cpuAccess(1'b0, ADDR_STATUS, '0, rd);
        checkValue(rd, 32'h1, "status after reset");
        setCtrl(3'b100);
        cpuAccess(1'b0, ADDR_CTRL, '0, rd);
        checkValue(rd, 32'h4, "ctrl readback");
        regWrite(ADDR_MADDR, 32'h1234_5678);
        cpuAccess(1'b0, ADDR_MADDR, '0, rd);
        checkValue(rd, 32'h1234_5678, "maddr readback");
        regWrite(ADDR_COUNT, 32'h55);
        cpuAccess(1'b0, ADDR_COUNT, '0, rd);
        checkValue(rd, 32'h55, "count readback");
        regWrite(ADDR_COUNT, '0);

        // Interrupt gating by intEna
        scsiInt = 1'b1;
        @(negedge nSCLK);
        checkValue(intOut, 1'b1, "int_o with scsiInt");
        cpuAccess(1'b0, ADDR_STATUS, '0, rd);
        checkValue(rd, 32'h1 | (32'h1 << STAT_SCSIINT), "status with scsiInt");
        setCtrl(3'b000);
        @(negedge nSCLK);
        checkValue(intOut, 1'b0, "int_o gated off");
        scsiInt = 1'b0;

        // Register window
        regWrite(ADDR_SCSI, 32'(winExp));
        cpuAccess(1'b0, ADDR_SCSI, '0, rd);
        checkValue(rd, 32'(winExp), "window read");

        // Peripheral to memory
        regWrite(ADDR_MADDR, 32'h40);
        regWrite(ADDR_COUNT, NWORDS);
        dreqEna = 1'b1;
        setCtrl(3'b101);
        waitDone();
        for (int i = 0; i < NWORDS; i++) begin
            exp = {chip.srcBytes[4*i+3], chip.srcBytes[4*i+2],
                   chip.srcBytes[4*i+1], chip.srcBytes[4*i]};
            checkValue(memArr[8'h10 + i], exp, "packed memory word");
        end
        cpuAccess(1'b0, ADDR_COUNT, '0, rd);
        checkValue(rd, '0, "count after DMA");
        checkValue(intOut, 1'b1, "int_o on done");
        regWrite(ADDR_STATUS, 32'h1 << STAT_DONE);
        @(negedge nSCLK);
        checkValue(intOut, 1'b0, "int_o after done clear");
        dreqEna = 1'b0;
        setCtrl(3'b000);

        // Memory to peripheral
        @(negedge nSCLK);
        chipClear = 1'b1;
        @(negedge nSCLK);
        chipClear = 1'b0;
        for (int i = 0; i < NWORDS; i++) begin
            srcWords[i]       = $urandom;
            memArr[8'h20 + i] = srcWords[i];
        end
        regWrite(ADDR_MADDR, 32'h80);
        regWrite(ADDR_COUNT, NWORDS);
        dreqEna = 1'b1;
        setCtrl(3'b011);
        waitDone();
        while (logCount < 8'(NWORDS * 4))
            @(negedge nSCLK);
        for (int i = 0; i < NWORDS * 4; i++)
            checkValue(chip.logBytes[i], srcWords[i / 4][8 * (i % 4) +: 8],
                       "byte at peripheral");
        for (int i = 0; i < NWORDS; i++)
            checkValue(memArr[8'h20 + i], srcWords[i], "memory kept by read DMA");
        dreqEna = 1'b0;
        regWrite(ADDR_STATUS, 32'h1 << STAT_DONE);
        setCtrl(3'b000);

        repeat (4) @(negedge nSCLK);
        $display("Checks done with %0d value errors and %0d protocol errors",
                 errCount, protoCount);
        if (errCount == 0 && protoCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
